// ==== project.f ====
+incdir+hdl
hdl/lsu_pkg.sv
hdl/lsu_req_stage.sv
hdl/lsu_inflight_buf.sv
hdl/lsu_data_mem.sv
hdl/lsu_resp_stage.sv
hdl/lsu_top.sv
tests/lsu_tb.sv

// ==== Makefile ====
# Verilator build and run for the LSU testbench

VERILATOR ?= verilator
TOP       := lsu_tb
RTL_TOP   := lsu_top
FILELIST  := project.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# The run passes only when the pass line shows up in the output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '** PASS **'

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== tests/lsu_tb.sv ====
// LSU testbench
// Drives decode micro-ops into lsu_top, models memory and writeback
// order with a reference array and a scoreboard queue

`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsu_tb;
  import lsu_pkg::*;

  localparam int MAX_CYCLES = 4000;

  typedef struct packed {
    word_t     pc;
    seq_num_t  seq_num;
    areg_t     waddr;
    preg_t     preg;
    preg_t     ppreg;
    logic      wen;
    word_t     wdata;
  } wb_exp_t;

  logic clk = 1'b0;
  logic rst;
  logic d_val, d_rdy, w_val, w_rdy, w_wen;
  lsu_uop_e d_uop;
  word_t d_pc, d_op1, d_op2, d_store_data, w_pc, w_wdata;
  seq_num_t d_seq_num, w_seq_num;
  areg_t d_waddr, w_waddr;
  preg_t d_preg, d_ppreg, w_preg, w_ppreg;

  word_t    ref_mem [`LSU_MEM_WORDS];
  wb_exp_t  sb [$];          // Expected writebacks, oldest first
  wb_exp_t  exp_head;
  logic     exp_avail;
  logic [2:0] since_dec;     // Edges since the last decode transfer
  logic     chk_reset, lat_arm, rand_rdy;
  integer   seed = 32'h0323eb6c;
  int       errors, err_mark, tests_passed, tests_failed, cycles;
  word_t    uop_count;
  string    cur_test;

  always #5 clk = ~clk;

  lsu_top u_lsu_top (
    .clk(clk), .rst(rst),
    .d_val(d_val), .d_rdy(d_rdy), .d_uop(d_uop), .d_pc(d_pc),
    .d_seq_num(d_seq_num), .d_op1(d_op1), .d_op2(d_op2),
    .d_store_data(d_store_data), .d_waddr(d_waddr), .d_preg(d_preg),
    .d_ppreg(d_ppreg),
    .w_val(w_val), .w_rdy(w_rdy), .w_pc(w_pc), .w_seq_num(w_seq_num),
    .w_waddr(w_waddr), .w_preg(w_preg), .w_ppreg(w_ppreg), .w_wen(w_wen),
    .w_wdata(w_wdata)
  );

  // --------------------------------------------------
  // Reference model and scoreboard
  // --------------------------------------------------

  always @(posedge clk) begin
    wb_exp_t e;
    word_t   addr;
    if (rst) begin
      sb.delete();
      exp_avail <= 1'b0;
      since_dec <= 3'd7;
    end else begin
      if (w_val && w_rdy && sb.size() > 0) begin
        void'(sb.pop_front());
      end
      if (d_val && d_rdy) begin
        addr      = d_op1 + d_op2;
        e.pc      = d_pc;
        e.seq_num = d_seq_num;
        e.waddr   = d_waddr;
        e.preg    = d_preg;
        e.ppreg   = d_ppreg;
        e.wen     = (d_uop == UOP_LW);
        if (d_uop == UOP_SW) begin
          ref_mem[addr[9:2]] = d_store_data;  // Stores complete in order
          e.wdata = '0;
        end else begin
          e.wdata = ref_mem[addr[9:2]];
        end
        sb.push_back(e);
        since_dec <= 3'd0;
      end else if (since_dec != 3'd7) begin
        since_dec <= since_dec + 3'd1;
      end
      exp_avail <= (sb.size() > 0);
      if (sb.size() > 0) exp_head <= sb[0];
    end
  end

  // --------------------------------------------------
  // Checks, sampled mid-cycle where everything is settled
  // --------------------------------------------------

  reset_state_a: assert property (@(negedge clk) disable iff (rst)
    chk_reset |-> (d_rdy && !w_val))
    else begin
      errors++;
      $display("FAILED %s: expected d_rdy=1 w_val=0, actual d_rdy=%b w_val=%b",
               cur_test, d_rdy, w_val);
    end

  wb_expected_a: assert property (@(negedge clk) disable iff (rst)
    (w_val && w_rdy) |-> exp_avail)
    else begin
      errors++;
      $display("%s: writeback arrived with no decode outstanding", cur_test);
    end

  wb_data_a: assert property (@(negedge clk) disable iff (rst)
    (w_val && w_rdy && exp_avail) |-> (w_wdata == exp_head.wdata))
    else begin
      errors++;
      $display("FAILED %s: wdata expected %h, actual %h", cur_test, exp_head.wdata, w_wdata);
    end

  wb_wen_a: assert property (@(negedge clk) disable iff (rst)
    (w_val && w_rdy && exp_avail) |-> (w_wen == exp_head.wen))
    else begin
      errors++;
      $display("FAILED %s: wen expected %b, actual %b", cur_test, exp_head.wen, w_wen);
    end

  wb_pc_a: assert property (@(negedge clk) disable iff (rst)
    (w_val && w_rdy && exp_avail) |-> (w_pc == exp_head.pc && w_seq_num == exp_head.seq_num))
    else begin
      errors++;
      $display("FAILED %s: pc/seq expected %h/%h, actual %h/%h", cur_test,
               exp_head.pc, exp_head.seq_num, w_pc, w_seq_num);
    end

  wb_regs_a: assert property (@(negedge clk) disable iff (rst)
    (w_val && w_rdy && exp_avail) |->
      ({w_waddr, w_preg, w_ppreg} == {exp_head.waddr, exp_head.preg, exp_head.ppreg}))
    else begin
      errors++;
      $display("FAILED %s: waddr/preg/ppreg expected %h/%h/%h, actual %h/%h/%h", cur_test,
               exp_head.waddr, exp_head.preg, exp_head.ppreg, w_waddr, w_preg, w_ppreg);
    end

  // Idle unit: writeback exactly one cycle after the request edge
  latency_a: assert property (@(negedge clk) disable iff (rst)
    lat_arm |-> (w_val == (since_dec == 3'd1)))
    else begin
      errors++;
      $display("FAILED %s: w_val expected %b, actual %b", cur_test, since_dec == 3'd1, w_val);
    end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
      $display("** FAIL **");
      $finish;
    end
  end

  // --------------------------------------------------
  // Stimulus helpers
  // --------------------------------------------------

  task automatic next_cycle();
    @(posedge clk);
    #1;
    if (rand_rdy) w_rdy = (($random(seed) & 3) != 0);  // Ready about 3 of 4 cycles
  endtask

  // Holds d_val and payload until the decode transfer
  task automatic send_uop(input lsu_uop_e uop, input word_t op1, input word_t op2,
                          input word_t sdata);
    logic took;
    d_val        = 1'b1;
    d_uop        = uop;
    d_pc         = 32'h0000_1000 + (uop_count << 2);
    d_seq_num    = seq_num_t'(uop_count);
    d_op1        = op1;
    d_op2        = op2;
    d_store_data = sdata;
    d_waddr      = areg_t'($random(seed));
    d_preg       = preg_t'($random(seed));
    d_ppreg      = preg_t'($random(seed));
    took = 1'b0;
    while (!took) begin
      @(negedge clk);
      took = d_rdy;
      next_cycle();
    end
    d_val     = 1'b0;
    uop_count = uop_count + 32'd1;
  endtask

  task automatic send_random();
    word_t    addr;
    word_t    op1;
    lsu_uop_e uop;
    addr      = $random(seed);
    addr[9:6] = 4'h0;       // Sixteen words, lots of reuse
    op1       = $random(seed);
    uop       = (($random(seed) & 1) != 0) ? UOP_SW : UOP_LW;
    send_uop(uop, op1, addr - op1, $random(seed));
  endtask

  task automatic drain();
    rand_rdy = 1'b0;
    w_rdy    = 1'b1;
    while (sb.size() != 0) next_cycle();
    next_cycle();
  endtask

  task automatic begin_test(input string name);
    cur_test = name;
    err_mark = errors;
  endtask

  task automatic end_test();
    if (errors == err_mark) begin
      tests_passed++;
      $display("test %-12s done, no errors", cur_test);
    end else begin
      tests_failed++;
      $display("test %-12s done, %0d errors", cur_test, errors - err_mark);
    end
  endtask

  // --------------------------------------------------
  // Tests
  // --------------------------------------------------

  initial begin
    word_t target;
    word_t op1;
    rst          = 1'b1;
    d_val        = 1'b0;
    d_uop        = UOP_LW;
    d_pc         = '0;
    d_seq_num    = '0;
    d_op1        = '0;
    d_op2        = '0;
    d_store_data = '0;
    d_waddr      = '0;
    d_preg       = '0;
    d_ppreg      = '0;
    w_rdy        = 1'b1;
    chk_reset    = 1'b0;
    lat_arm      = 1'b0;
    rand_rdy     = 1'b0;
    errors       = 0;
    tests_passed = 0;
    tests_failed = 0;
    cycles       = 0;
    uop_count    = '0;
    cur_test     = "none";
    for (int i = 0; i < `LSU_MEM_WORDS; i++) ref_mem[i] = '0;

    repeat (3) @(posedge clk);
    #1 rst = 1'b0;

    begin_test("reset");
    chk_reset = 1'b1;
    next_cycle();
    chk_reset = 1'b0;
    end_test();

    begin_test("load_store");
    for (int i = 0; i < 8; i++) send_uop(UOP_SW, 32'h40 + (word_t'(i) << 2), '0, $random(seed));
    for (int i = 0; i < 4; i++) send_uop(UOP_SW, '0, 32'h40 + (word_t'(i) << 3), $random(seed));
    for (int i = 0; i < 8; i++) send_uop(UOP_LW, 32'h40 + (word_t'(i) << 2), '0, '0);
    drain();
    end_test();

    begin_test("addr_sum");
    target = 32'h0000_02a0;
    send_uop(UOP_SW, target, '0, 32'hcafe_f00d);
    send_uop(UOP_LW, target, '0, '0);
    send_uop(UOP_LW, '0, target, '0);
    send_uop(UOP_LW, 32'h100, 32'h1a0, '0);
    send_uop(UOP_LW, 32'hffff_fff0, 32'h2b0, '0);  // Wraps around
    for (int i = 0; i < 4; i++) begin
      op1 = $random(seed);
      send_uop(UOP_LW, op1, target + word_t'(i) - op1, '0);  // Low bits ignored
    end
    drain();
    end_test();

    begin_test("meta_order");
    for (int i = 0; i < 24; i++) send_random();
    drain();
    end_test();

    begin_test("latency");
    lat_arm = 1'b1;
    for (int i = 0; i < 3; i++) begin
      send_random();
      drain();
    end
    lat_arm = 1'b0;
    end_test();

    begin_test("backpressure");
    rand_rdy = 1'b1;
    for (int i = 0; i < 200; i++) begin
      repeat ($random(seed) & 3) next_cycle();  // Idle gap on decode
      send_random();
    end
    drain();
    end_test();

    $display("tests passed %0d, tests failed %0d, check errors %0d",
             tests_passed, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// ==== hdl/lsu_top.sv ====
// LSU top level
// Request stage, in-flight buffer, data memory and response stage

`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsu_top (
  input  logic               clk,
  input  logic               rst,

  // Decode
  input  logic               d_val,
  output logic               d_rdy,
  input  lsu_pkg::lsu_uop_e  d_uop,
  input  lsu_pkg::word_t     d_pc,
  input  lsu_pkg::seq_num_t  d_seq_num,
  input  lsu_pkg::word_t     d_op1,
  input  lsu_pkg::word_t     d_op2,
  input  lsu_pkg::word_t     d_store_data,
  input  lsu_pkg::areg_t     d_waddr,
  input  lsu_pkg::preg_t     d_preg,
  input  lsu_pkg::preg_t     d_ppreg,

  // Writeback
  output logic               w_val,
  input  logic               w_rdy,
  output lsu_pkg::word_t     w_pc,
  output lsu_pkg::seq_num_t  w_seq_num,
  output lsu_pkg::areg_t     w_waddr,
  output lsu_pkg::preg_t     w_preg,
  output lsu_pkg::preg_t     w_ppreg,
  output logic               w_wen,
  output lsu_pkg::word_t     w_wdata
);
  import lsu_pkg::*;

  // Memory request and response
  logic      mem_req_val;
  logic      mem_req_rdy;
  mem_op_e   mem_req_op;
  word_t     mem_req_addr;
  word_t     mem_req_data;
  logic      mem_resp_val;
  logic      mem_resp_rdy;
  word_t     mem_resp_data;

  // In-flight buffer
  logic      buf_push;
  logic      buf_pop;
  logic      buf_full;
  logic      buf_empty;
  word_t     push_pc;
  seq_num_t  push_seq_num;
  areg_t     push_waddr;
  preg_t     push_preg;
  preg_t     push_ppreg;
  logic      push_wen;
  word_t     head_pc;
  seq_num_t  head_seq_num;
  areg_t     head_waddr;
  preg_t     head_preg;
  preg_t     head_ppreg;
  logic      head_wen;

  lsu_req_stage u_req_stage (
    .clk          (clk),
    .rst          (rst),
    .d_val        (d_val),
    .d_rdy        (d_rdy),
    .d_uop        (d_uop),
    .d_pc         (d_pc),
    .d_seq_num    (d_seq_num),
    .d_op1        (d_op1),
    .d_op2        (d_op2),
    .d_store_data (d_store_data),
    .d_waddr      (d_waddr),
    .d_preg       (d_preg),
    .d_ppreg      (d_ppreg),
    .mem_req_val  (mem_req_val),
    .mem_req_rdy  (mem_req_rdy),
    .mem_req_op   (mem_req_op),
    .mem_req_addr (mem_req_addr),
    .mem_req_data (mem_req_data),
    .buf_full     (buf_full),
    .buf_push     (buf_push),
    .push_pc      (push_pc),
    .push_seq_num (push_seq_num),
    .push_waddr   (push_waddr),
    .push_preg    (push_preg),
    .push_ppreg   (push_ppreg),
    .push_wen     (push_wen)
  );

  lsu_inflight_buf u_inflight_buf (
    .clk          (clk),
    .rst          (rst),
    .push         (buf_push),
    .push_pc      (push_pc),
    .push_seq_num (push_seq_num),
    .push_waddr   (push_waddr),
    .push_preg    (push_preg),
    .push_ppreg   (push_ppreg),
    .push_wen     (push_wen),
    .pop          (buf_pop),
    .full         (buf_full),
    .empty        (buf_empty),
    .head_pc      (head_pc),
    .head_seq_num (head_seq_num),
    .head_waddr   (head_waddr),
    .head_preg    (head_preg),
    .head_ppreg   (head_ppreg),
    .head_wen     (head_wen)
  );

  lsu_data_mem u_data_mem (
    .clk           (clk),
    .rst           (rst),
    .mem_req_val   (mem_req_val),
    .mem_req_rdy   (mem_req_rdy),
    .mem_req_op    (mem_req_op),
    .mem_req_addr  (mem_req_addr),
    .mem_req_data  (mem_req_data),
    .mem_resp_val  (mem_resp_val),
    .mem_resp_rdy  (mem_resp_rdy),
    .mem_resp_data (mem_resp_data)
  );

  lsu_resp_stage u_resp_stage (
    .mem_resp_val  (mem_resp_val),
    .mem_resp_rdy  (mem_resp_rdy),
    .mem_resp_data (mem_resp_data),
    .buf_empty     (buf_empty),
    .buf_pop       (buf_pop),
    .head_pc       (head_pc),
    .head_seq_num  (head_seq_num),
    .head_waddr    (head_waddr),
    .head_preg     (head_preg),
    .head_ppreg    (head_ppreg),
    .head_wen      (head_wen),
    .w_val         (w_val),
    .w_rdy         (w_rdy),
    .w_pc          (w_pc),
    .w_seq_num     (w_seq_num),
    .w_waddr       (w_waddr),
    .w_preg        (w_preg),
    .w_ppreg       (w_ppreg),
    .w_wen         (w_wen),
    .w_wdata       (w_wdata)
  );

endmodule

// ==== hdl/lsu_resp_stage.sv ====
// LSU response stage
// Pairs each memory response with the oldest buffered metadata and
// presents the combined writeback, with no added cycles

`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsu_resp_stage (
  // Memory response
  input  logic               mem_resp_val,
  output logic               mem_resp_rdy,
  input  lsu_pkg::word_t     mem_resp_data,

  // In-flight buffer head
  input  logic               buf_empty,
  output logic               buf_pop,
  input  lsu_pkg::word_t     head_pc,
  input  lsu_pkg::seq_num_t  head_seq_num,
  input  lsu_pkg::areg_t     head_waddr,
  input  lsu_pkg::preg_t     head_preg,
  input  lsu_pkg::preg_t     head_ppreg,
  input  logic               head_wen,

  // Writeback
  output logic               w_val,
  input  logic               w_rdy,
  output lsu_pkg::word_t     w_pc,
  output lsu_pkg::seq_num_t  w_seq_num,
  output lsu_pkg::areg_t     w_waddr,
  output lsu_pkg::preg_t     w_preg,
  output lsu_pkg::preg_t     w_ppreg,
  output logic               w_wen,
  output lsu_pkg::word_t     w_wdata
);
  import lsu_pkg::*;

  logic  meta_avail;  // Head entry present to pair with
  logic  w_xfer;

  // ------------------------------------------------
  // Pairing
  // ------------------------------------------------

  assign meta_avail = !buf_empty;

  assign w_val        = mem_resp_val & meta_avail;
  assign w_xfer       = w_val & w_rdy;
  assign mem_resp_rdy = w_rdy & meta_avail;  // Drain only along with writeback
  assign buf_pop      = w_xfer;

  // Writeback fields
  assign w_pc      = head_pc;
  assign w_seq_num = head_seq_num;
  assign w_waddr   = head_waddr;
  assign w_preg    = head_preg;
  assign w_ppreg   = head_ppreg;
  assign w_wen     = head_wen;
  assign w_wdata   = mem_resp_data;   // Zero for stores

  // Every response was pushed into the buffer when its request left,
  // so a response with nothing buffered means lost metadata
  always_comb begin
    if (mem_resp_val) begin
      resp_has_meta_a: assert #0 (meta_avail)
        else $error("lsu_resp_stage: memory response with empty buffer");
    end
  end

endmodule

// ==== hdl/lsu_data_mem.sv ====
// LSU data memory
// Single-ported word memory with a one-entry response register;
// back-pressure on the response stalls new requests

`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsu_data_mem (
  input  logic              clk,
  input  logic              rst,

  // Request
  input  logic              mem_req_val,
  output logic              mem_req_rdy,
  input  lsu_pkg::mem_op_e  mem_req_op,
  input  lsu_pkg::word_t    mem_req_addr,
  input  lsu_pkg::word_t    mem_req_data,

  // Response
  output logic              mem_resp_val,
  input  logic              mem_resp_rdy,
  output lsu_pkg::word_t    mem_resp_data
);
  import lsu_pkg::*;

  localparam int WORDS    = `LSU_MEM_WORDS;
  localparam int IDX_BITS = $clog2(WORDS);

  word_t               mem [WORDS];
  logic [IDX_BITS-1:0] idx;        // Word index, byte offset dropped
  logic                req_xfer;
  logic                resp_xfer;

  assign idx       = mem_req_addr[IDX_BITS+1:2];
  assign req_xfer  = mem_req_val & mem_req_rdy;
  assign resp_xfer = mem_resp_val & mem_resp_rdy;

  // Free slot, or the held response leaves this cycle
  assign mem_req_rdy = !mem_resp_val | mem_resp_rdy;

  // ------------------------------------------------
  // Storage
  // ------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < WORDS; i++) begin
        mem[i] <= '0;
      end
    end else if (req_xfer && mem_req_op == MEM_WRITE) begin
      mem[idx] <= mem_req_data;
    end
  end

  // ------------------------------------------------
  // Response register
  // ------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      mem_resp_val <= 1'b0;
    end else if (req_xfer) begin
      mem_resp_val <= 1'b1;
    end else if (resp_xfer) begin
      mem_resp_val <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (req_xfer) begin
      // Writes answer with zero data
      mem_resp_data <= (mem_req_op == MEM_READ) ? mem[idx] : '0;
    end
  end

  // A stalled response holds until the response stage takes it
  resp_hold_a: assert property (@(posedge clk) disable iff (rst)
    mem_resp_val && !mem_resp_rdy |=> mem_resp_val && $stable(mem_resp_data))
    else $error("lsu_data_mem: response changed while stalled");

endmodule

// ==== hdl/lsu_inflight_buf.sv ====
// LSU in-flight buffer
// Circular FIFO of writeback metadata for requests awaiting a response

`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsu_inflight_buf (
  input  logic               clk,
  input  logic               rst,

  input  logic               push,
  input  lsu_pkg::word_t     push_pc,
  input  lsu_pkg::seq_num_t  push_seq_num,
  input  lsu_pkg::areg_t     push_waddr,
  input  lsu_pkg::preg_t     push_preg,
  input  lsu_pkg::preg_t     push_ppreg,
  input  logic               push_wen,

  input  logic               pop,
  output logic               full,
  output logic               empty,

  output lsu_pkg::word_t     head_pc,
  output lsu_pkg::seq_num_t  head_seq_num,
  output lsu_pkg::areg_t     head_waddr,
  output lsu_pkg::preg_t     head_preg,
  output lsu_pkg::preg_t     head_ppreg,
  output logic               head_wen
);
  import lsu_pkg::*;

  localparam int DEPTH    = `LSU_INFLIGHT_DEPTH;
  localparam int PTR_BITS = $clog2(DEPTH);
  localparam int CNT_BITS = $clog2(DEPTH + 1);

  // Entry storage, one array per field
  word_t     pc_q      [DEPTH];
  seq_num_t  seq_num_q [DEPTH];
  areg_t     waddr_q   [DEPTH];
  preg_t     preg_q    [DEPTH];
  preg_t     ppreg_q   [DEPTH];
  logic      wen_q     [DEPTH];

  logic [PTR_BITS-1:0] wr_ptr;
  logic [PTR_BITS-1:0] rd_ptr;
  logic [CNT_BITS-1:0] count;

  assign full  = (count == CNT_BITS'(DEPTH));
  assign empty = (count == '0);

  // ------------------------------------------------
  // Pointers and occupancy
  // ------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end  // Both at once leave the count as is
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      pc_q[wr_ptr]      <= push_pc;
      seq_num_q[wr_ptr] <= push_seq_num;
      waddr_q[wr_ptr]   <= push_waddr;
      preg_q[wr_ptr]    <= push_preg;
      ppreg_q[wr_ptr]   <= push_ppreg;
      wen_q[wr_ptr]     <= push_wen;
    end
  end

  // Oldest entry
  assign head_pc      = pc_q[rd_ptr];
  assign head_seq_num = seq_num_q[rd_ptr];
  assign head_waddr   = waddr_q[rd_ptr];
  assign head_preg    = preg_q[rd_ptr];
  assign head_ppreg   = ppreg_q[rd_ptr];
  assign head_wen     = wen_q[rd_ptr];

  no_overflow_a: assert property (@(posedge clk) disable iff (rst) !(push && full))
    else $error("lsu_inflight_buf: push while full");

  no_underflow_a: assert property (@(posedge clk) disable iff (rst) !(pop && empty))
    else $error("lsu_inflight_buf: pop while empty");

endmodule

// ==== hdl/lsu_req_stage.sv ====
// LSU request stage
// Registers a decode micro-op, forms op1 + op2 and issues the memory
// request while pushing its writeback metadata into the in-flight buffer

`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsu_req_stage (
  input  logic               clk,
  input  logic               rst,

  // Decode
  input  logic               d_val,
  output logic               d_rdy,
  input  lsu_pkg::lsu_uop_e  d_uop,
  input  lsu_pkg::word_t     d_pc,
  input  lsu_pkg::seq_num_t  d_seq_num,
  input  lsu_pkg::word_t     d_op1,
  input  lsu_pkg::word_t     d_op2,
  input  lsu_pkg::word_t     d_store_data,
  input  lsu_pkg::areg_t     d_waddr,
  input  lsu_pkg::preg_t     d_preg,
  input  lsu_pkg::preg_t     d_ppreg,

  // Memory request
  output logic               mem_req_val,
  input  logic               mem_req_rdy,
  output lsu_pkg::mem_op_e   mem_req_op,
  output lsu_pkg::word_t     mem_req_addr,
  output lsu_pkg::word_t     mem_req_data,

  // In-flight buffer push
  input  logic               buf_full,
  output logic               buf_push,
  output lsu_pkg::word_t     push_pc,
  output lsu_pkg::seq_num_t  push_seq_num,
  output lsu_pkg::areg_t     push_waddr,
  output lsu_pkg::preg_t     push_preg,
  output lsu_pkg::preg_t     push_ppreg,
  output logic               push_wen
);
  import lsu_pkg::*;

  logic      op_val;      // Stage register holds a micro-op
  lsu_uop_e  op_uop;
  word_t     op_pc;
  seq_num_t  op_seq_num;
  word_t     op_op1;
  word_t     op_op2;
  word_t     op_data;
  areg_t     op_waddr;
  preg_t     op_preg;
  preg_t     op_ppreg;

  logic      d_xfer;
  logic      req_xfer;

  // ------------------------------------------------
  // Stage register
  // ------------------------------------------------

  assign d_xfer   = d_val & d_rdy;
  assign req_xfer = mem_req_val & mem_req_rdy;
  assign d_rdy    = !op_val | req_xfer;  // Empty, or leaving this cycle

  always_ff @(posedge clk) begin
    if (rst) begin
      op_val <= 1'b0;
    end else if (d_xfer) begin
      op_val <= 1'b1;
    end else if (req_xfer) begin
      op_val <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (d_xfer) begin
      op_uop     <= d_uop;
      op_pc      <= d_pc;
      op_seq_num <= d_seq_num;
      op_op1     <= d_op1;
      op_op2     <= d_op2;
      op_data    <= d_store_data;
      op_waddr   <= d_waddr;
      op_preg    <= d_preg;
      op_ppreg   <= d_ppreg;
    end
  end

  // ------------------------------------------------
  // Memory request
  // ------------------------------------------------

  always_comb begin
    case (op_uop)
      UOP_SW:  mem_req_op = MEM_WRITE;
      default: mem_req_op = MEM_READ;
    endcase
  end

  // Hold back while no buffer slot is free for the metadata
  assign mem_req_val  = op_val & !buf_full;
  assign mem_req_addr = op_op1 + op_op2;
  assign mem_req_data = op_data;

  // Metadata enters the buffer with the request
  assign buf_push     = req_xfer;
  assign push_pc      = op_pc;
  assign push_seq_num = op_seq_num;
  assign push_waddr   = op_waddr;
  assign push_preg    = op_preg;
  assign push_ppreg   = op_ppreg;
  assign push_wen     = (op_uop == UOP_LW);  // Stores retire without a write

  // Decode only offers loads and stores
  uop_known_a: assert property (@(posedge clk) disable iff (rst)
    d_val |-> d_uop inside {UOP_LW, UOP_SW})
    else $error("lsu_req_stage: unknown micro-op from decode");

endmodule

// ==== hdl/lsu_pkg.sv ====
// LSU shared types
// Vector typedefs for the meaningful widths and the op encodings

`include "lsu_cfg.svh"

package lsu_pkg;

  // ------------------------------------------------
  // Vectors
  // ------------------------------------------------

  typedef logic [`LSU_XLEN-1:0]      word_t;     // Data or address
  typedef logic [`LSU_SEQ_BITS-1:0]  seq_num_t;
  typedef logic [4:0]                areg_t;     // Architectural register
  typedef logic [`LSU_PREG_BITS-1:0] preg_t;

  // ------------------------------------------------
  // Encodings
  // ------------------------------------------------

  // Micro-ops issued by decode
  typedef enum logic [1:0] {
    UOP_LW = 2'd0,
    UOP_SW = 2'd1
  } lsu_uop_e;

  // Memory request operation
  typedef enum logic {
    MEM_READ  = 1'b0,
    MEM_WRITE = 1'b1
  } mem_op_e;

endpackage

// ==== hdl/lsu_cfg.svh ====
// LSU configuration
// Datapath widths, in-flight buffer depth and data memory size

`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// ------------------------------------------------
// Datapath
// ------------------------------------------------

`define LSU_XLEN            32   // Data and address width
`define LSU_SEQ_BITS        4    // Instruction sequence number
`define LSU_PREG_BITS       6    // Physical register index

// ------------------------------------------------
// Storage
// ------------------------------------------------

// Requests waiting on a memory response
`define LSU_INFLIGHT_DEPTH  4

`define LSU_MEM_WORDS       256  // Word-addressed, indexed by addr[9:2]

`endif
